//--- sim/decode_patterns.txt
# W addr data | D name instr mwe rwe wds waddr pc alu2 imm shamt r1addr
# X addr data name instr ... writes and decodes in the same cycle
W 01 11111111
W 02 22222222
W 03 80000003
W 04 44444444
W 00 deadbeef
D add 00222820 0 1 0 05 0 0 00002820 00 01
D sll 00023100 0 1 0 06 0 0 00003100 04 02
D sra 00033fc3 0 1 0 07 0 0 00003fc3 1f 03
D slt 0064402a 0 1 0 08 0 0 0000402a 00 03
D xor 00817826 0 1 0 0f 0 0 00007826 00 04
D andi 30298001 0 1 0 09 0 2 00008001 00 01
D ori 346cf0f0 0 1 0 0c 0 2 0000f0f0 00 03
D addi 204afffe 0 1 0 0a 0 1 fffffffe 00 02
D addiu 246e7fff 0 1 0 0e 0 1 00007fff 00 03
D lui 3c0b1234 0 1 0 0b 0 1 00001234 10 00
D jr 00800008 0 0 0 00 2 0 00000008 00 04
D j 08100040 0 0 0 10 2 1 00000040 00 00
D jal 0c000abc 0 0 0 00 2 1 00000abc 00 00
D beq 1022fffc 0 0 0 02 1 0 fffffffc 00 01
D bne 14600008 0 0 0 00 1 0 00000008 00 03
D lw 8c2dfff8 0 1 1 0d 0 1 fffffff8 00 01
D sw ac82000c 1 1 0 02 0 1 0000000c 00 04
X 01 0f0f0f0f addSameCycleWrite 00222820 0 1 0 05 0 0 00002820 00 01
D addAfterWrite 00222820 0 1 0 05 0 0 00002820 00 01

//--- sources.f
+incdir+include
source/mipsPkg.sv
source/instructionCategorize.sv
source/controlGenerate.sv
source/operandSelect.sv
source/registerFile.sv
source/decodeStage.sv
sim/decodeStage_properties.sv
sim/decodeChecker.sv
sim/decodeStage_tb.sv

//--- Makefile
# Verilator build and run for the decode stage testbench.

VERILATOR ?= verilator
TOP ?= decodeStage_tb
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := include/mips_macros.svh
PATTERNS := sim/decode_patterns.txt
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY) $(PATTERNS)
	./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Fail message found in $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "Run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/decodeStage_tb.sv
`timescale 1ns/1ps

module decodeStage_tb;

	logic clock;
	logic rstN;
	logic instrValid;
	logic [31:0] instr;
	logic writeEnable;
	logic [4:0] writeAddr;
	logic [31:0] writeData;
	logic outValid;
	logic memoryWriteEnable;
	logic registerWriteEnable;
	logic registerWriteDataSource;
	logic [4:0] registerWriteAddr;
	logic [1:0] pcAction;
	logic [1:0] aluData2Source;
	logic [31:0] data1;
	logic [31:0] data2;
	logic [31:0] immediate;
	logic [4:0] shamt;
	int testCount;
	int errorCount;
	int tbErrors;
	int issued;

	decodeStage dut_i (.*);

	decodeChecker check_i (.*);

	always #5 clock = ~clock;

	// Consumes the rest of a comment line.
	task automatic skipLine(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1) begin
			ch = $fgetc(fd);
		end
	endtask

	initial begin
		int fd;
		int code;
		int waited;
		string kind;
		string name;
		logic [31:0] addrVal;
		logic [31:0] dataVal;
		logic [31:0] instrVal;
		logic [31:0] f [0:8];
		clock = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		writeEnable = 1'b0;
		writeAddr = '0;
		writeData = '0;
		tbErrors = 0;
		issued = 0;
		repeat (3) @(posedge clock);
		#1 rstN = 1'b1;
		// A couple of idle cycles let the checker see quiet outputs after reset.
		repeat (2) @(posedge clock);
		fd = $fopen("sim/decode_patterns.txt", "r");
		if (fd == 0) begin
			$display("Error: could not open the pattern file sim/decode_patterns.txt");
			tbErrors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", kind);
				if (code != 1) break;
				if (kind == "#") begin
					skipLine(fd);
					continue;
				end
				addrVal = '0;
				dataVal = '0;
				if (kind == "W" || kind == "X") begin
					code = $fscanf(fd, "%h %h", addrVal, dataVal);
				end
				if (kind == "D" || kind == "X") begin
					code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h", name, instrVal,
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				end
				@(posedge clock);
				#1;
				writeEnable = (kind == "W" || kind == "X");
				writeAddr = addrVal[4:0];
				writeData = dataVal;
				instrValid = (kind == "D" || kind == "X");
				if (instrValid) begin
					instr = instrVal;
					check_i.expectResult(name, f[0][0], f[1][0], f[2][0], f[3][4:0],
						f[4][1:0], f[5][1:0], f[6], f[7][4:0], f[8][4:0]);
					issued++;
				end
			end
			$fclose(fd);
		end
		@(posedge clock);
		#1;
		instrValid = 1'b0;
		writeEnable = 1'b0;
		waited = 0;
		while (testCount < issued && waited < 20) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (testCount < issued) begin
			$display("Error: timed out waiting for outValid, %0d of %0d results seen",
				testCount, issued);
			tbErrors++;
		end
		$display("Tests run: %0d, failed checks: %0d, other errors: %0d",
			testCount, errorCount, tbErrors);
		if (errorCount == 0 && tbErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- sim/decodeChecker.sv
`timescale 1ns/1ps

module decodeChecker (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input logic [31:0] instr,
	input logic writeEnable,
	input logic [4:0] writeAddr,
	input logic [31:0] writeData,
	input logic outValid,
	input logic memoryWriteEnable,
	input logic registerWriteEnable,
	input logic registerWriteDataSource,
	input logic [4:0] registerWriteAddr,
	input logic [1:0] pcAction,
	input logic [1:0] aluData2Source,
	input logic [31:0] data1,
	input logic [31:0] data2,
	input logic [31:0] immediate,
	input logic [4:0] shamt,
	output int testCount,
	output int errorCount
);

	typedef struct packed {
		logic mwe;
		logic rwe;
		logic wds;
		logic [4:0] waddr;
		logic [1:0] pc;
		logic [1:0] alu2;
		logic [31:0] imm;
		logic [4:0] shamt;
		logic [4:0] r1;
	} expectT;

	expectT expectQ [$];
	string nameQ [$];
	// Top bit marks a shadow entry whose value is known.
	logic [32:0] read1Q [$];
	logic [32:0] read2Q [$];
	int cycleQ [$];
	logic [31:0] shadow [0:31];
	logic known [0:31];
	int cycle;

	initial begin
		testCount = 0;
		errorCount = 0;
		cycle = 0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
			known[i] = 1'b0;
		end
		known[0] = 1'b1;
	end

	task automatic expectResult(input string name, input logic mwe, input logic rwe,
		input logic wds, input logic [4:0] waddr, input logic [1:0] pc, input logic [1:0] alu2,
		input logic [31:0] imm, input logic [4:0] sh, input logic [4:0] r1);
		expectQ.push_back({mwe, rwe, wds, waddr, pc, alu2, imm, sh, r1});
		nameQ.push_back(name);
	endtask

	task automatic compareField(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual, inout int fails);
		if (actual !== expected) begin
			$display("FAILED %s %s expected %h actual %h", name, field, expected, actual);
			fails++;
		end
	endtask

	always @(posedge clock) begin
		expectT exp;
		string name;
		logic [32:0] r1;
		logic [32:0] r2;
		int sampled;
		int fails;
		cycle = cycle + 1;
		if (rstN) begin
			if (!outValid && (memoryWriteEnable || registerWriteEnable)) begin
				$display("Error: a write enable is high while outValid is low");
				errorCount++;
			end
			if (outValid) begin
				if (expectQ.size() == 0 || read1Q.size() == 0) begin
					$display("Error: outValid is high with no instruction in flight");
					errorCount++;
				end else begin
					exp = expectQ.pop_front();
					name = nameQ.pop_front();
					r1 = read1Q.pop_front();
					r2 = read2Q.pop_front();
					sampled = cycleQ.pop_front();
					fails = 0;
					compareField(name, "latency", 32'(sampled + 1), 32'(cycle), fails);
					compareField(name, "memoryWriteEnable", 32'(exp.mwe), 32'(memoryWriteEnable),
						fails);
					compareField(name, "registerWriteEnable", 32'(exp.rwe), 32'(registerWriteEnable),
						fails);
					compareField(name, "registerWriteDataSource", 32'(exp.wds),
						32'(registerWriteDataSource), fails);
					compareField(name, "registerWriteAddr", 32'(exp.waddr), 32'(registerWriteAddr),
						fails);
					compareField(name, "pcAction", 32'(exp.pc), 32'(pcAction), fails);
					compareField(name, "aluData2Source", 32'(exp.alu2), 32'(aluData2Source),
						fails);
					compareField(name, "immediate", exp.imm, immediate, fails);
					compareField(name, "shamt", 32'(exp.shamt), 32'(shamt), fails);
					// Registers never written have no defined value to compare.
					if (r1[32]) compareField(name, "data1", r1[31:0], data1, fails);
					if (r2[32]) compareField(name, "data2", r2[31:0], data2, fails);
					if (fails == 0) $display("ok %s", name);
					errorCount += fails;
					testCount++;
				end
			end
			if (instrValid) begin
				if (expectQ.size() == 0) begin
					$display("Error: instrValid sampled with no expected values queued");
					errorCount++;
				end else begin
					exp = expectQ[expectQ.size() - 1];
					// Reads see the file as it was before this edge's write.
					read1Q.push_back({known[exp.r1], shadow[exp.r1]});
					read2Q.push_back({known[instr[20:16]], shadow[instr[20:16]]});
					cycleQ.push_back(cycle);
				end
			end
			if (writeEnable && writeAddr != 5'd0) begin
				shadow[writeAddr] = writeData;
				known[writeAddr] = 1'b1;
			end
		end
	end

endmodule

//--- sim/decodeStage_properties.sv
`timescale 1ns/1ps

module decodeStage_properties (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input logic outValid,
	input logic [4:0] register1Addr,
	input logic [4:0] register2Addr,
	input logic [31:0] data1,
	input logic [31:0] data2
);

	assert property (@(posedge clock) disable iff (!rstN) instrValid |=> outValid)
		else $error("outValid did not follow instrValid by one cycle");

	assert property (@(posedge clock) disable iff (!rstN) !instrValid |=> !outValid)
		else $error("outValid rose without a sampled instruction");

	// Register 0 reads as zero on both ports.
	assert property (@(posedge clock) disable iff (!rstN) register1Addr == 5'd0 |=> data1 == '0)
		else $error("register 0 read nonzero on port 1");

	assert property (@(posedge clock) disable iff (!rstN) register2Addr == 5'd0 |=> data2 == '0)
		else $error("register 0 read nonzero on port 2");

endmodule

bind decodeStage decodeStage_properties props_i (
	.clock(clock),
	.rstN(rstN),
	.instrValid(instrValid),
	.outValid(outValid),
	.register1Addr(register1Addr),
	.register2Addr(register2Addr),
	.data1(data1),
	.data2(data2)
);

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input instrT instr,
	input logic writeEnable,
	input regAddrT writeAddr,
	input dataT writeData,
	output logic outValid,
	output logic memoryWriteEnable,
	output logic registerWriteEnable,
	output logic registerWriteDataSource,
	output regAddrT registerWriteAddr,
	output pcActionT pcAction,
	output aluSrcT aluData2Source,
	output dataT data1,
	output dataT data2,
	output dataT immediate,
	output shamtT shamt
);

	opFuncT opFunc;
	categoryT category;
	logic decodedMemoryWriteEnable;
	logic decodedRegisterWriteEnable;
	logic registerWriteAddrSource;
	logic decodedRegisterWriteDataSource;
	logic register1AddrSource;
	pcActionT decodedPcAction;
	aluSrcT decodedAluData2Source;
	shamtSrcT shamtSource;
	regAddrT register1Addr;
	regAddrT register2Addr;

	instructionCategorize categorize_i (
		.instr(instr),
		.opFunc(opFunc),
		.category(category)
	);

	controlGenerate control_i (
		.opFunc(opFunc),
		.category(category),
		.memoryWriteEnable(decodedMemoryWriteEnable),
		.registerWriteEnable(decodedRegisterWriteEnable),
		.registerWriteAddrSource(registerWriteAddrSource),
		.registerWriteDataSource(decodedRegisterWriteDataSource),
		.register1AddrSource(register1AddrSource),
		.pcAction(decodedPcAction),
		.aluData2Source(decodedAluData2Source),
		.shamtSource(shamtSource)
	);

	operandSelect select_i (
		.clock(clock),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.registerWriteAddrSource(registerWriteAddrSource),
		.decodedRegisterWriteDataSource(decodedRegisterWriteDataSource),
		.register1AddrSource(register1AddrSource),
		.decodedPcAction(decodedPcAction),
		.decodedAluData2Source(decodedAluData2Source),
		.shamtSource(shamtSource),
		.decodedMemoryWriteEnable(decodedMemoryWriteEnable),
		.decodedRegisterWriteEnable(decodedRegisterWriteEnable),
		.register1Addr(register1Addr),
		.register2Addr(register2Addr),
		.outValid(outValid),
		.memoryWriteEnable(memoryWriteEnable),
		.registerWriteEnable(registerWriteEnable),
		.registerWriteDataSource(registerWriteDataSource),
		.registerWriteAddr(registerWriteAddr),
		.pcAction(pcAction),
		.aluData2Source(aluData2Source),
		.immediate(immediate),
		.shamt(shamt)
	);

	registerFile registers_i (
		.clock(clock),
		.rstN(rstN),
		.readAddr1(register1Addr),
		.readAddr2(register2Addr),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readData1(data1),
		.readData2(data2)
	);

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
	input logic clock,
	input logic rstN,
	input regAddrT readAddr1,
	input regAddrT readAddr2,
	input logic writeEnable,
	input regAddrT writeAddr,
	input dataT writeData,
	output dataT readData1,
	output dataT readData2
);

	// Register 0 has no storage.
	dataT registers [1:31];

	always_ff @(posedge clock) begin
		if (writeEnable && writeAddr != '0) begin
			registers[writeAddr] <= writeData;
		end
	end

	// Reads sample the array before this edge's write lands.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			readData1 <= '0;
			readData2 <= '0;
		end else begin
			readData1 <= (readAddr1 == '0) ? '0 : registers[readAddr1];
			readData2 <= (readAddr2 == '0) ? '0 : registers[readAddr2];
		end
	end

endmodule

//--- source/operandSelect.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

module operandSelect import mipsPkg::*; (
	input logic clock,
	input logic rstN,
	input logic instrValid,
	input instrT instr,
	input logic registerWriteAddrSource,
	input logic decodedRegisterWriteDataSource,
	input logic register1AddrSource,
	input pcActionT decodedPcAction,
	input aluSrcT decodedAluData2Source,
	input shamtSrcT shamtSource,
	input logic decodedMemoryWriteEnable,
	input logic decodedRegisterWriteEnable,
	output regAddrT register1Addr,
	output regAddrT register2Addr,
	output logic outValid,
	output logic memoryWriteEnable,
	output logic registerWriteEnable,
	output logic registerWriteDataSource,
	output regAddrT registerWriteAddr,
	output pcActionT pcAction,
	output aluSrcT aluData2Source,
	output dataT immediate,
	output shamtT shamt
);

	dataT immediateNext;
	shamtT shamtNext;
	logic memoryWriteEnableQ;
	logic registerWriteEnableQ;

	assign register1Addr = (register1AddrSource == `R1ADDR_RT) ? instr[`INSTR_RT] : instr[`INSTR_RS];
	assign register2Addr = instr[`INSTR_RT];

	// Branches and arithmetic use the signed form.
	assign immediateNext = (decodedAluData2Source == `ALU2_IMM_UNSIGNED) ?
		{16'b0, instr[`INSTR_IMM]} :
		{{16{instr[`INSTR_IMM_SIGN]}}, instr[`INSTR_IMM]};

	always_comb begin
		case (shamtSource)
			`SHAMT_FIELD: shamtNext = instr[`INSTR_SHAMT];
			`SHAMT_CONST16: shamtNext = `LUI_SHIFT;
			default: shamtNext = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= instrValid;
		end
	end

	always_ff @(posedge clock) begin
		if (instrValid) begin
			memoryWriteEnableQ <= decodedMemoryWriteEnable;
			registerWriteEnableQ <= decodedRegisterWriteEnable;
			registerWriteDataSource <= decodedRegisterWriteDataSource;
			registerWriteAddr <= (registerWriteAddrSource == `WADDR_RD) ?
				instr[`INSTR_RD] : instr[`INSTR_RT];
			pcAction <= decodedPcAction;
			aluData2Source <= decodedAluData2Source;
			immediate <= immediateNext;
			shamt <= shamtNext;
		end
	end

	// Enables are only meaningful alongside a valid result.
	assign memoryWriteEnable = outValid & memoryWriteEnableQ;
	assign registerWriteEnable = outValid & registerWriteEnableQ;

endmodule

//--- source/controlGenerate.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

module controlGenerate import mipsPkg::*; (
	input opFuncT opFunc,
	input categoryT category,
	output logic memoryWriteEnable,
	output logic registerWriteEnable,
	output logic registerWriteAddrSource,
	output logic registerWriteDataSource,
	output logic register1AddrSource,
	output pcActionT pcAction,
	output aluSrcT aluData2Source,
	output shamtSrcT shamtSource
);

	logic isRType;

	assign isRType = (opFunc[`OPFUNC_OP] == `OP_SPECIAL);

	assign memoryWriteEnable = (category == `CAT_STORE);

	// R-type writes rd, everything else writes rt.
	assign registerWriteAddrSource = isRType ? `WADDR_RD : `WADDR_RT;

	always_comb begin
		case (category)
			`CAT_RJUMP,
			`CAT_JUMP,
			`CAT_BRANCH:
				registerWriteEnable = 1'b0;
			default:
				registerWriteEnable = 1'b1;
		endcase
	end

	assign registerWriteDataSource = (category == `CAT_LOAD) ? `WDATA_MEMORY : `WDATA_ALU;

	// Shifts take their operand from rt.
	assign register1AddrSource = (category == `CAT_RSHIFT) ? `R1ADDR_RT : `R1ADDR_RS;

	always_comb begin
		case (category)
			`CAT_JUMP,
			`CAT_RJUMP:
				pcAction = `PC_JUMP;
			`CAT_BRANCH:
				pcAction = `PC_BRANCH;
			default:
				pcAction = `PC_INC;
		endcase
	end

	always_comb begin
		if (isRType) begin
			aluData2Source = `ALU2_REGISTER;
		end else begin
			case (category)
				`CAT_BRANCH:
					aluData2Source = `ALU2_REGISTER;
				`CAT_LOGIC:
					aluData2Source = `ALU2_IMM_UNSIGNED;
				default:
					aluData2Source = `ALU2_IMM_SIGNED;
			endcase
		end
	end

	always_comb begin
		if (category == `CAT_RSHIFT) begin
			shamtSource = `SHAMT_FIELD;
		end else if (opFunc == {`OP_LUI, 6'b0}) begin
			shamtSource = `SHAMT_CONST16;
		end else begin
			shamtSource = `SHAMT_NONE;
		end
	end

endmodule

//--- source/instructionCategorize.sv
`timescale 1ns/1ps

`include "mips_macros.svh"

module instructionCategorize import mipsPkg::*; (
	input instrT instr,
	output opFuncT opFunc,
	output categoryT category
);

	opcodeT opcode;
	funcT func;

	assign opcode = instr[`INSTR_OPCODE];
	assign func = instr[`INSTR_FUNC];

	// Only R-type instructions keep their function bits.
	assign opFunc = (opcode == `OP_SPECIAL) ? {opcode, func} : {opcode, 6'b0};

	always_comb begin
		case (opFunc[`OPFUNC_OP])
			`OP_SPECIAL: begin
				case (opFunc[5:0])
					`FUNC_ADD,
					`FUNC_ADDU,
					`FUNC_SUB,
					`FUNC_SUBU,
					`FUNC_AND,
					`FUNC_OR,
					`FUNC_XOR,
					`FUNC_NOR,
					`FUNC_SLT:
						category = `CAT_ALU;
					`FUNC_SLL,
					`FUNC_SRL,
					`FUNC_SRA:
						category = `CAT_RSHIFT;
					`FUNC_JR:
						category = `CAT_RJUMP;
					default:
						category = `CAT_OTHER;
				endcase
			end
			`OP_J,
			`OP_JAL:
				category = `CAT_JUMP;
			`OP_BEQ,
			`OP_BNE:
				category = `CAT_BRANCH;
			`OP_ANDI,
			`OP_ORI,
			`OP_XORI:
				category = `CAT_LOGIC;
			`OP_ADDI,
			`OP_ADDIU,
			`OP_SLTI:
				category = `CAT_ARITH;
			`OP_LUI:
				category = `CAT_LUI;
			`OP_LW:
				category = `CAT_LOAD;
			`OP_SW:
				category = `CAT_STORE;
			default:
				category = `CAT_OTHER;
		endcase
	end

endmodule

//--- source/mipsPkg.sv
package mipsPkg;

	// One full instruction word.
	typedef logic [31:0] instrT;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] funcT;

	// Opcode in the upper half, function in the lower half.
	// The function half is zero unless the opcode is SPECIAL.
	typedef logic [11:0] opFuncT;

	typedef logic [4:0] regAddrT;
	typedef logic [31:0] dataT;
	typedef logic [4:0] shamtT;

	typedef logic [3:0] categoryT;

	// Next program counter behaviour.
	typedef logic [1:0] pcActionT;

	// Second ALU operand: register, signed or unsigned immediate.
	typedef logic [1:0] aluSrcT;

	// Shift amount: none, instruction field or the lui constant.
	typedef logic [1:0] shamtSrcT;

endpackage

//--- include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Instruction field positions.
`define INSTR_OPCODE 31:26
`define INSTR_RS 25:21
`define INSTR_RT 20:16
`define INSTR_RD 15:11
`define INSTR_SHAMT 10:6
`define INSTR_FUNC 5:0
`define INSTR_IMM 15:0
`define INSTR_IMM_SIGN 15
`define OPFUNC_OP 11:6

`define OP_SPECIAL 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI 6'h0a
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_XORI 6'h0e
`define OP_LUI 6'h0f
`define OP_LW 6'h23
`define OP_SW 6'h2b

`define FUNC_SLL 6'h00
`define FUNC_SRL 6'h02
`define FUNC_SRA 6'h03
`define FUNC_JR 6'h08
`define FUNC_ADD 6'h20
`define FUNC_ADDU 6'h21
`define FUNC_SUB 6'h22
`define FUNC_SUBU 6'h23
`define FUNC_AND 6'h24
`define FUNC_OR 6'h25
`define FUNC_XOR 6'h26
`define FUNC_NOR 6'h27
`define FUNC_SLT 6'h2a

`define CAT_ALU 4'd0
`define CAT_RSHIFT 4'd1
`define CAT_RJUMP 4'd2
`define CAT_JUMP 4'd3
`define CAT_BRANCH 4'd4
`define CAT_LOGIC 4'd5
`define CAT_ARITH 4'd6
`define CAT_LUI 4'd7
`define CAT_LOAD 4'd8
`define CAT_STORE 4'd9
`define CAT_OTHER 4'd10

`define WADDR_RD 1'b0
`define WADDR_RT 1'b1
`define WDATA_ALU 1'b0
`define WDATA_MEMORY 1'b1
`define R1ADDR_RS 1'b0
`define R1ADDR_RT 1'b1
`define PC_INC 2'd0
`define PC_BRANCH 2'd1
`define PC_JUMP 2'd2
`define ALU2_REGISTER 2'd0
`define ALU2_IMM_SIGNED 2'd1
`define ALU2_IMM_UNSIGNED 2'd2
`define SHAMT_NONE 2'd0
`define SHAMT_FIELD 2'd1
`define SHAMT_CONST16 2'd2

// Shift amount that lui applies to its immediate.
`define LUI_SHIFT 5'd16

`endif
